//--- flist.f
+incdir+rtl
rtl/vp_pkg.sv
rtl/vp_clk_enables.sv
rtl/vp_input_ctrl.sv
rtl/vp_cart_mapper.sv
rtl/vp_cart_rom.sv
rtl/vp_palette.sv
rtl/vp_glue_top.sv
testbench/vp_glue_asserts.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_top.sv
// Testbench top: random stimulus, reference models for all five blocks, report
`timescale 1ns/100ps

module tb_top;
	import vp_pkg::*;

	localparam int WAIT_MAX = 64;  // Clocks per wait before timeout
	localparam int IMG_SIZES [5] = '{4096, 8192, 16384, 2048, 4096};

	// Copy of the palette tables
	localparam rgb24_t NTSC_TAB [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};
	localparam rgb24_t PAL_TAB [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	// Scancode table, same order in both arrays
	localparam byte_t KEY_CODES [46] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45,
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
		8'h29, 8'h79, 8'h7B, 8'h7C, 8'h4A, 8'h55, 8'h1F, 8'h27, 8'h5A, 8'h66
	};
	localparam byte_t KEY_CHARS [46] = '{
		"1", "2", "3", "4", "5", "6", "7", "8", "9", "0",
		"a", "b", "c", "d", "e", "f", "g", "h", "i", "j",
		"k", "l", "m", "n", "o", "p", "q", "r", "s", "t",
		"u", "v", "w", "x", "y", "z",
		" ", "+", "-", "*", "/", "=", 8'h11, 8'h12, 8'h0A, 8'h08
	};

	logic       clk_sys;
	logic       reset;
	logic       pal;
	logic       joy_swap;
	joy_raw_t   joy0;
	joy_raw_t   joy1;
	ps2_key_t   ps2_key;
	dl_port_t   dl;
	cart_bus_t  cart;
	vdc_color_t vdc_color;
	logic       cpu_en;
	logic       vdc_en;
	joy_ctrl_t  joy;
	key_evt_t   key;
	byte_t      cart_data;
	rgb24_t     rgb;

	int    seed = 85504;
	int    errors = 0;
	int    checks = 0;
	int    tests_done = 0;
	byte_t model_mem [16384];  // Cartridge ROM model
	logic  model_xrom;
	int    model_size;

	tb_clock u_clock (
		.clk_sys_o (clk_sys),
		.reset_o   (reset)
	);

	vp_glue_top u_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pal_i       (pal),
		.joy_swap_i  (joy_swap),
		.joy0_i      (joy0),
		.joy1_i      (joy1),
		.ps2_key_i   (ps2_key),
		.dl_i        (dl),
		.cart_i      (cart),
		.vdc_color_i (vdc_color),
		.cpu_en_o    (cpu_en),
		.vdc_en_o    (vdc_en),
		.joy_o       (joy),
		.key_o       (key),
		.cart_data_o (cart_data),
		.rgb_o       (rgb)
	);

	//////////////////////////////
	// Models
	//////////////////////////////

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	// Cartridge address to ROM address by image layout
	function automatic int rom_map(input cart_bus_t c, input logic xrom, input int size);
		int low;
		low = int'(c.addr[11]) * 1024 + int'(c.addr[9:0]);  // A10 skipped
		if (xrom) begin
			return int'(c.addr);
		end
		case (size)
			4096:    return int'(c.bs0) * 2048 + low;
			8192:    return int'(c.bs1) * 4096 + int'(c.bs0) * 2048 + low;
			16384:   return int'(c.bs1) * 8192 + int'(c.bs0) * 4096 + int'(c.addr);
			default: return low;
		endcase
	endfunction

	function automatic byte_t key_model(input byte_t code);
		for (int i = 0; i < 46; i++) begin
			if (KEY_CODES[6'(i)] == code) begin
				return KEY_CHARS[6'(i)];
			end
		end
		return 8'h00;  // Not in the table
	endfunction

	// Key 1 has the highest priority, key 0 the lowest
	function automatic byte_t pad_model(input logic [9:0] keys);
		for (int i = 0; i < 10; i++) begin
			if (keys[4'(i)]) begin
				return (i == 9) ? "0" : 8'("1" + i);
			end
		end
		return 8'h00;
	endfunction

	function automatic joy_ctrl_t joy_expect(input logic swap, input joy_raw_t j0,
		input joy_raw_t j1);
		joy_raw_t  a;
		joy_raw_t  b;
		joy_ctrl_t e;
		a = swap ? j1 : j0;
		b = swap ? j0 : j1;
		e.right_n  = ~{a[0], b[0]};
		e.left_n   = ~{a[1], b[1]};
		e.down_n   = ~{a[2], b[2]};
		e.up_n     = ~{a[3], b[3]};
		e.action_n = ~{a[4], b[4]};
		e.reset_n  = !(a[5] && b[5]);
		return e;
	endfunction

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Clocks until the next enable pulse, sampled on the falling edge
	task automatic wait_pulse(input logic vdc_sel, output int gap, output logic ok);
		ok = 1'b0;
		gap = 0;
		while (!ok && gap < WAIT_MAX) begin
			@(negedge clk_sys);
			gap++;
			ok = vdc_sel ? vdc_en : cpu_en;
		end
		if (!ok) begin
			$display("Timeout: no %s enable pulse within %0d clocks",
				vdc_sel ? "VDC" : "CPU", WAIT_MAX);
			errors++;
		end
	endtask

	task automatic wait_key(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
			ok = key.valid;
		end
		if (!ok) begin
			$display("Timeout: no key event within %0d clocks", WAIT_MAX);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_done++;
		$display("Test %s done: %0d errors", name, errors - start_errors);
	endtask

	task automatic download_image(input byte_t index, input int size);
		byte_t data;
		@(posedge clk_sys);
		cart.rd_n <= 1'b1;  // ROM read idle during the load
		dl.active <= 1'b1;
		dl.index  <= index;
		dl.wr     <= 1'b0;
		for (int i = 0; i < size; i++) begin
			@(posedge clk_sys);
			data = 8'($random(seed));
			dl.wr   <= 1'b1;
			dl.addr <= 25'(i);
			dl.data <= data;
			model_mem[14'(i)] = data;
		end
		@(posedge clk_sys);
		dl.wr     <= 1'b0;
		dl.active <= 1'b0;
		model_xrom = (index == 8'd2);
		model_size = size;
		@(posedge clk_sys);  // Idle clock before the next image
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic divider_test();
		int   gap;
		logic ok;
		int   cpu_div;
		int   vdc_div;
		int   start;
		start = errors;
		for (int mode = 0; mode < 2; mode++) begin
			@(posedge clk_sys);
			pal <= 1'(mode);
			repeat (3) @(posedge clk_sys);  // Let the restart settle
			cpu_div = (mode != 0) ? 12 : 8;
			vdc_div = (mode != 0) ? 10 : 6;
			wait_pulse(1'b0, gap, ok);
			for (int n = 0; n < 3; n++) begin
				wait_pulse(1'b0, gap, ok);
				if (ok) check_value("cpu_en_o spacing", gap, cpu_div);
			end
			wait_pulse(1'b1, gap, ok);
			for (int n = 0; n < 3; n++) begin
				wait_pulse(1'b1, gap, ok);
				if (ok) check_value("vdc_en_o spacing", gap, vdc_div);
			end
		end
		finish_test("dividers", start);
	endtask

	task automatic cart_test();
		cart_bus_t c;
		logic      rd_en;
		logic      exp_valid;
		byte_t     exp_data;
		int        start;
		start = errors;
		exp_valid = 1'b0;  // Read register is unknown until the first read
		exp_data = 8'h00;
		for (int img = 0; img < 5; img++) begin
			download_image((img == 4) ? 8'd2 : 8'(rand_below(2)), IMG_SIZES[img]);
			for (int n = 0; n < 200; n++) begin
				c = 16'($random(seed));
				@(posedge clk_sys);
				cart <= c;
				@(posedge clk_sys);
				@(negedge clk_sys);
				rd_en = model_xrom ? (!c.rd_n && !(c.cs_n && c.bs0)) : !c.rd_n;
				if (rd_en) begin
					exp_data = model_mem[14'(rom_map(c, model_xrom, model_size))];
					exp_valid = 1'b1;
				end
				if (exp_valid) check_value("cart_data_o", 32'(cart_data), 32'(exp_data));
			end
		end
		finish_test("cartridge", start);
	endtask

	task automatic palette_test();
		vdc_color_t code;
		logic       mode;
		rgb24_t     exp;
		int         start;
		start = errors;
		for (int n = 0; n < 100; n++) begin
			code = 4'($random(seed));
			mode = 1'($random(seed));
			@(posedge clk_sys);
			pal       <= mode;
			vdc_color <= code;
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp = mode ? PAL_TAB[code] : NTSC_TAB[code];
			check_value("rgb_o", 32'(rgb), 32'(exp));
		end
		finish_test("palette", start);
	endtask

	task automatic key_test();
		byte_t code;
		logic  pressed;
		logic  ok;
		int    start;
		start = errors;
		for (int n = 0; n < 150; n++) begin
			if (rand_below(4) == 0) begin
				code = 8'($random(seed));  // Mostly outside the table
			end else begin
				code = KEY_CODES[6'(rand_below(46))];
			end
			pressed = 1'($random(seed));
			@(posedge clk_sys);
			ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
			wait_key(ok);
			if (ok) begin
				check_value("key_o.ascii", 32'(key.ascii), 32'(key_model(code)));
				check_value("key_o.released", 32'(key.released), 32'(!pressed));
				@(negedge clk_sys);
				check_value("key_o.valid", 32'(key.valid), 32'd0);  // One clock only
			end
		end
		finish_test("keys", start);
	endtask

	task automatic joy_test();
		joy_raw_t   j0;
		joy_raw_t   j1;
		logic       swap;
		logic       ok;
		logic [9:0] keys;
		int         start;
		start = errors;
		for (int n = 0; n < 100; n++) begin
			j0 = 16'($random(seed));
			j1 = 16'($random(seed));
			swap = 1'($random(seed));
			@(posedge clk_sys);
			joy0     <= j0;
			joy1     <= j1;
			joy_swap <= swap;
			@(negedge clk_sys);
			check_value("joy_o", 32'(joy), 32'(joy_expect(swap, j0, j1)));
		end
		// Numpad presses on either port
		for (int n = 0; n < 40; n++) begin
			@(posedge clk_sys);
			joy0 <= '0;
			joy1 <= '0;
			repeat (3) @(posedge clk_sys);  // Release event passes
			keys = 10'($random(seed));
			if (keys == 10'd0) keys = 10'h200;
			@(posedge clk_sys);
			if (rand_below(2) == 0) begin
				joy0 <= {keys, 6'b0};
			end else begin
				joy1 <= {keys, 6'b0};
			end
			wait_key(ok);
			if (ok) check_value("key_o.ascii", 32'(key.ascii), 32'(pad_model(keys)));
		end
		finish_test("joysticks", start);
	endtask

	initial begin
		int n;
		pal = 1'b0;
		joy_swap = 1'b0;
		joy0 = '0;
		joy1 = '0;
		ps2_key = '0;
		dl = '0;
		cart = '0;
		cart.rd_n = 1'b1;
		cart.cs_n = 1'b1;
		vdc_color = '0;
		n = 0;
		while (reset && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		if (reset) begin
			$display("Timeout: reset was never released");
			errors++;
		end else begin
			divider_test();
			cart_test();
			palette_test();
			key_test();
			joy_test();
		end
		repeat (4) @(posedge clk_sys);
		errors += u_dut.u_asserts.fail_cnt;
		$display("Summary: %0d tests, %0d checks, %0d assertion failures, %0d errors",
			tests_done, checks, u_dut.u_asserts.fail_cnt, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and reset source, 4 ns clk_sys and an 8-cycle reset
`timescale 1ns/100ps

module tb_clock (
	output logic clk_sys_o,
	output logic reset_o
);

	initial begin
		clk_sys_o = 1'b0;
		forever #2 clk_sys_o = ~clk_sys_o;  // 250 MHz
	end

	initial begin
		reset_o = 1'b1;
		repeat (8) @(posedge clk_sys_o);
		reset_o <= 1'b0;
	end

endmodule

//--- testbench/vp_glue_asserts.sv
// Concurrent checks on the clock enables and key events, bound into vp_glue_top
`timescale 1ns/100ps

module vp_glue_asserts (
	input logic              clk_sys_i,
	input logic              reset_i,
	input logic              cpu_en_i,
	input logic              vdc_en_i,
	input vp_pkg::key_evt_t  key_i
);

	int fail_cnt = 0;  // Summed into the final count by tb_top

	// Enables are single-clock pulses
	cpu_en_single : assert property (@(posedge clk_sys_i) disable iff (reset_i)
		!(cpu_en_i && $past(cpu_en_i)))
		else begin
			fail_cnt++;
			$error("cpu_en_o high for two clocks in a row");
		end

	vdc_en_single : assert property (@(posedge clk_sys_i) disable iff (reset_i)
		!(vdc_en_i && $past(vdc_en_i)))
		else begin
			fail_cnt++;
			$error("vdc_en_o high for two clocks in a row");
		end

	key_quiet_in_reset : assert property (@(posedge clk_sys_i) reset_i |-> !key_i.valid)
		else begin
			fail_cnt++;
			$error("key_o.valid high during reset");
		end

endmodule

bind vp_glue_top vp_glue_asserts u_asserts (
	.clk_sys_i (clk_sys),
	.reset_i   (reset),
	.cpu_en_i  (cpu_en_o),
	.vdc_en_i  (vdc_en_o),
	.key_i     (key_o)
);

//--- rtl/vp_glue_top.sv
// Glue top level: clock enables, input path, cartridge mapping and ROM, palette
`timescale 1ns/100ps

module vp_glue_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               pal_i,
	input  logic               joy_swap_i,
	input  vp_pkg::joy_raw_t   joy0_i,
	input  vp_pkg::joy_raw_t   joy1_i,
	input  vp_pkg::ps2_key_t   ps2_key_i,
	input  vp_pkg::dl_port_t   dl_i,
	input  vp_pkg::cart_bus_t  cart_i,
	input  vp_pkg::vdc_color_t vdc_color_i,
	output logic               cpu_en_o,
	output logic               vdc_en_o,
	output vp_pkg::joy_ctrl_t  joy_o,
	output vp_pkg::key_evt_t   key_o,
	output vp_pkg::byte_t      cart_data_o,
	output vp_pkg::rgb24_t     rgb_o
);
	import vp_pkg::*;

	// Mapper to ROM
	rom_addr_t rom_addr;
	logic      rom_wr;
	logic      rom_rd;
	byte_t     rom_wdata;

	vp_clk_enables u_clk_en (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	vp_input_ctrl u_input (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.joy_swap_i (joy_swap_i),
		.joy0_i     (joy0_i),
		.joy1_i     (joy1_i),
		.ps2_key_i  (ps2_key_i),
		.joy_o      (joy_o),
		.key_o      (key_o)
	);

	//////////////////////////////
	// Cartridge
	//////////////////////////////

	vp_cart_mapper u_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_i       (dl_i),
		.cart_i     (cart_i),
		.rom_addr_o (rom_addr),
		.rom_wr_o   (rom_wr),
		.rom_rd_o   (rom_rd),
		.rom_data_o (rom_wdata)
	);

	vp_cart_rom u_rom (
		.clk_sys (clk_sys),
		.addr_i  (rom_addr),
		.wr_i    (rom_wr),
		.rd_i    (rom_rd),
		.data_i  (rom_wdata),
		.data_o  (cart_data_o)  // One clock after rd
	);

	vp_palette u_palette (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pal_i   (pal_i),
		.color_i (vdc_color_i),
		.rgb_o   (rgb_o)
	);

endmodule

//--- rtl/vp_palette.sv
// Registered NTSC and PAL colour lookup from the VDC RGB+luma code
`timescale 1ns/100ps

module vp_palette (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               pal_i,
	input  vp_pkg::vdc_color_t color_i,
	output vp_pkg::rgb24_t     rgb_o
);
	import vp_pkg::*;

	// Calibrated NTSC colours, index is {R, G, B, luma}
	localparam rgb24_t NTSC_LUT [16] = '{
		24'h000000, 24'h676767,  // Black
		24'h1a37be, 24'h5c80f6,  // Blue
		24'h006d07, 24'h56c469,  // Green
		24'h2aaabe, 24'h77e6eb,  // Cyan
		24'h790000, 24'hc75151,  // Red
		24'h94309f, 24'hdc84e8,  // Magenta
		24'h77670b, 24'hc6b86a,  // Yellow
		24'hcecece, 24'hffffff   // White
	};

	// PAL set is flatter
	localparam rgb24_t PAL_LUT [16] = '{
		24'h000000, 24'h494949,
		24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949,
		24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49,
		24'hb6b6b6, 24'hffffff
	};

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else begin
			rgb_o <= pal_i ? PAL_LUT[color_i] : NTSC_LUT[color_i];
		end
	end

endmodule

//--- rtl/vp_cart_rom.sv
// Single-port synchronous 16 KiB cartridge memory
`timescale 1ns/100ps
`include "vp_consts.svh"

module vp_cart_rom (
	input  logic              clk_sys,
	input  vp_pkg::rom_addr_t addr_i,
	input  logic              wr_i,
	input  logic              rd_i,
	input  vp_pkg::byte_t     data_i,
	output vp_pkg::byte_t     data_o
);
	import vp_pkg::*;

	byte_t mem [2**`VP_ROM_AW];

	always_ff @(posedge clk_sys) begin
		if (wr_i) begin
			mem[addr_i] <= data_i;
		end
		if (rd_i) begin
			data_o <= mem[addr_i];  // Held while rd_i is low
		end
	end

endmodule

//--- rtl/vp_cart_mapper.sv
// Download tracking, image size count, XROM flag and cartridge ROM address/enable
`timescale 1ns/100ps
`include "vp_consts.svh"

module vp_cart_mapper (
	input  logic              clk_sys,
	input  logic              reset,
	input  vp_pkg::dl_port_t  dl_i,
	input  vp_pkg::cart_bus_t cart_i,
	output vp_pkg::rom_addr_t rom_addr_o,
	output logic              rom_wr_o,
	output logic              rom_rd_o,
	output vp_pkg::byte_t     rom_data_o
);
	import vp_pkg::*;

	logic      dl_active_q;
	logic      is_cart;       // Index 0..2 targets the cartridge
	logic      dl_start;
	logic      xrom_q;
	img_size_t img_size_q;
	rom_addr_t map_addr;

	assign is_cart  = dl_i.index[1:0] < 2'(`VP_DL_IDX_FONT);
	assign dl_start = dl_i.active & ~dl_active_q & is_cart;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			xrom_q      <= 1'b0;
			img_size_q  <= '0;
		end else begin
			dl_active_q <= dl_i.active;
			if (dl_start) begin
				xrom_q     <= dl_i.index == byte_t'(`VP_DL_IDX_XROM);
				img_size_q <= img_size_t'(dl_i.wr);  // First byte may come with the edge
			end else if (dl_i.active & dl_i.wr & is_cart) begin
				img_size_q <= img_size_q + 16'd1;
			end
		end
	end

	// Bank layout by image size; A10 is not used below 16K
	always_comb begin
		if (xrom_q) begin
			map_addr = {2'b00, cart_i.addr};
		end else begin
			case (img_size_q)
				img_size_t'(`VP_CART_4K):
					map_addr = {2'b00, cart_i.bs0, cart_i.addr[11], cart_i.addr[9:0]};
				img_size_t'(`VP_CART_8K):
					map_addr = {1'b0, cart_i.bs1, cart_i.bs0, cart_i.addr[11],
						cart_i.addr[9:0]};
				img_size_t'(`VP_CART_16K):
					map_addr = {cart_i.bs1, cart_i.bs0, cart_i.addr};
				default:
					map_addr = {3'b000, cart_i.addr[11], cart_i.addr[9:0]};
			endcase
		end
	end

	assign rom_addr_o = (dl_i.active & is_cart) ? dl_i.addr[`VP_ROM_AW-1:0] : map_addr;
	assign rom_wr_o   = dl_i.active & dl_i.wr & is_cart;
	assign rom_data_o = dl_i.data;

	// XROM keeps the ROM off the bus while cs_n and bs0 are both high
	assign rom_rd_o = xrom_q ? (~cart_i.rd_n & ~(cart_i.cs_n & cart_i.bs0)) : ~cart_i.rd_n;

endmodule

//--- rtl/vp_input_ctrl.sv
// Joystick routing and key encoder for PS/2 scancodes and joystick numpads
`timescale 1ns/100ps

module vp_input_ctrl (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              joy_swap_i,
	input  vp_pkg::joy_raw_t  joy0_i,
	input  vp_pkg::joy_raw_t  joy1_i,
	input  vp_pkg::ps2_key_t  ps2_key_i,
	output vp_pkg::joy_ctrl_t joy_o,
	output vp_pkg::key_evt_t  key_o
);
	import vp_pkg::*;

	joy_raw_t   joy_a;
	joy_raw_t   joy_b;
	logic [9:0] numpad;     // Both pads ORed
	logic [9:0] numpad_q;
	logic       ps2_tgl_q;
	logic       ps2_evt;
	logic       pad_evt;
	byte_t      ps2_ascii;
	byte_t      pad_ascii;
	byte_t      pad_ascii_q;  // Last held numpad key
	logic       key_valid_q;
	logic       key_rel_q;
	byte_t      key_ascii_q;

	// Scancode set 2 to ASCII, extended bit ignored
	function automatic byte_t ps2_to_ascii(input byte_t code);
		case (code)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			8'h1F: return 8'h11;  // Left GUI, yes
			8'h27: return 8'h12;  // Right GUI, no
			8'h5A: return 8'h0A;  // Enter
			8'h66: return 8'h08;  // Backspace
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed key wins, key 1 first and key 0 last
	function automatic byte_t pad_to_ascii(input logic [9:0] keys);
		byte_t asc;
		asc = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (keys[i]) begin
				asc = (i == 9) ? "0" : byte_t'(8'h31 + i);
			end
		end
		return asc;
	endfunction

	//////////////////////////////
	// Joysticks
	//////////////////////////////

	assign joy_a = joy_swap_i ? joy1_i : joy0_i;
	assign joy_b = joy_swap_i ? joy0_i : joy1_i;

	// Console lines are low when pressed
	assign joy_o.right_n  = {~joy_a[0], ~joy_b[0]};
	assign joy_o.left_n   = {~joy_a[1], ~joy_b[1]};
	assign joy_o.down_n   = {~joy_a[2], ~joy_b[2]};
	assign joy_o.up_n     = {~joy_a[3], ~joy_b[3]};
	assign joy_o.action_n = {~joy_a[4], ~joy_b[4]};
	assign joy_o.reset_n  = ~(joy_a[5] & joy_b[5]);  // Needs both

	//////////////////////////////
	// Key events
	//////////////////////////////

	assign numpad    = joy_a[15:6] | joy_b[15:6];
	assign ps2_evt   = ps2_key_i[10] != ps2_tgl_q;
	assign pad_evt   = numpad != numpad_q;
	assign ps2_ascii = ps2_to_ascii(ps2_key_i[7:0]);
	assign pad_ascii = pad_to_ascii(numpad);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_tgl_q   <= 1'b0;
			numpad_q    <= '0;
			key_valid_q <= 1'b0;
		end else begin
			ps2_tgl_q   <= ps2_key_i[10];
			numpad_q    <= numpad;
			key_valid_q <= ps2_evt | pad_evt;  // Single-clock pulse
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ps2_evt) begin  // PS/2 wins a tie
			key_ascii_q <= ps2_ascii;
		end else if (pad_evt) begin
			key_ascii_q <= (|numpad) ? pad_ascii : pad_ascii_q;
		end
		if (|numpad) begin
			pad_ascii_q <= pad_ascii;
		end
		key_rel_q <= ~ps2_key_i[9] & ~(|numpad);
	end

	assign key_o = '{valid: key_valid_q, released: key_rel_q, ascii: key_ascii_q};

endmodule

//--- rtl/vp_clk_enables.sv
// CPU and VDC clock-enable pulse generators for NTSC and PAL timing
`timescale 1ns/100ps
`include "vp_consts.svh"

module vp_clk_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Channel 0 is the CPU, channel 1 the VDC
	logic [3:0] cnt [2];
	logic [3:0] last [2];
	logic [1:0] en_q;
	logic       pal_q;

	// Last count before wrap, per mode
	assign last[0] = pal_i ? 4'(`VP_CPU_DIV_PAL - 1) : 4'(`VP_CPU_DIV_NTSC - 1);
	assign last[1] = pal_i ? 4'(`VP_VDC_DIV_PAL - 1) : 4'(`VP_VDC_DIV_NTSC - 1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q <= 1'b0;
			en_q  <= '0;
			for (int ch = 0; ch < 2; ch++) begin
				cnt[ch] <= '0;
			end
		end else begin
			pal_q <= pal_i;
			for (int ch = 0; ch < 2; ch++) begin
				if (pal_i != pal_q) begin  // Mode change restarts both
					cnt[ch]  <= '0;
					en_q[ch] <= 1'b0;
				end else if (cnt[ch] >= last[ch]) begin
					cnt[ch]  <= '0;
					en_q[ch] <= 1'b1;
				end else begin
					cnt[ch]  <= cnt[ch] + 4'd1;
					en_q[ch] <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

//--- rtl/vp_pkg.sv
// Vector typedefs and packed structs shared by the glue logic
package vp_pkg;

	// Plain vectors
	typedef logic [11:0] cart_addr_t;  // Console cartridge address
	typedef logic [13:0] rom_addr_t;   // Cartridge ROM address
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] dl_addr_t;    // Download byte address
	typedef logic [15:0] img_size_t;   // Image byte count
	typedef logic [23:0] rgb24_t;
	typedef logic [3:0]  vdc_color_t;  // R, G, B, luma

	// Joystick word, active high
	// [0] right [1] left [2] down [3] up [4] action [5] reset
	// [6..14] numpad 1 to 9, [15] numpad 0
	typedef logic [15:0] joy_raw_t;

	// PS/2 event: [10] toggle, [9] pressed, [8] extended, [7:0] scancode
	typedef logic [10:0] ps2_key_t;

	// Download stream from the host
	typedef struct packed {
		logic     active;
		logic     wr;
		byte_t    index;
		dl_addr_t addr;
		byte_t    data;
	} dl_port_t;

	// Console cartridge outputs
	typedef struct packed {
		cart_addr_t addr;
		logic       bs0;
		logic       bs1;
		logic       rd_n;
		logic       cs_n;
	} cart_bus_t;

	// Joystick lines to the console, bit 1 port A, bit 0 port B
	typedef struct packed {
		logic [1:0] up_n;
		logic [1:0] down_n;
		logic [1:0] left_n;
		logic [1:0] right_n;
		logic [1:0] action_n;
		logic       reset_n;
	} joy_ctrl_t;

	// Key event for the keyboard matrix
	typedef struct packed {
		logic  valid;
		logic  released;
		byte_t ascii;
	} key_evt_t;

endpackage

//--- rtl/vp_consts.svh
// Constants for clock dividers, cartridge sizes, download indices and ROM width
`ifndef VP_CONSTS_SVH
`define VP_CONSTS_SVH

//////////////////////////////
// Clock-enable dividers
//////////////////////////////

// CPU enable period in clk_sys cycles
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL 12

// VDC enable period in clk_sys cycles
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL 10

//////////////////////////////
// Cartridge images
//////////////////////////////

// Image byte counts that pick a bank layout
`define VP_CART_4K 4096
`define VP_CART_8K 8192
`define VP_CART_16K 16384

// Cartridge ROM address width, 16 KiB
`define VP_ROM_AW 14

//////////////////////////////
// Download indices
//////////////////////////////

// XROM image, flat 4K map
`define VP_DL_IDX_XROM 2

// First index that is not a cartridge (font)
`define VP_DL_IDX_FONT 3

`endif
